// ==== src/lin_pkg.sv ====
// shared defaults for the multi-channel linear conditioner
// NCH is assumed a power of two and at least 2; modules derive their own tag width
// gain is signed fixed point with DWM-2 fraction bits, so 1.0 = 2**(DWM-2)
`default_nettype none

package lin_pkg;

  //////////////////////////////////////////////////////////////////////
  // channels
  //////////////////////////////////////////////////////////////////////

  parameter int unsigned NCH = 4;           // lanes built by the top level
  parameter int unsigned CHW = $clog2(NCH); // channel tag width

  //////////////////////////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////////////////////////

  parameter int unsigned DWI = 14;  // input sample, signed
  parameter int unsigned DWO = 14;  // output sample, signed
  parameter int unsigned DWM = 16;  // gain, signed, DWM-2 fraction bits
  parameter int unsigned DWS = DWO; // offset, same scale as output

  //////////////////////////////////////////////////////////////////////
  // configuration address layout
  //////////////////////////////////////////////////////////////////////

  // addr = {channel, select}
  parameter int unsigned CFG_AW = CHW + 1;
  parameter int unsigned CFG_DW = 16;     // write data width

  parameter logic CFG_SEL_GAIN = 1'b0;    // select bit for gain register
  parameter logic CFG_SEL_OFFS = 1'b1;    // select bit for offset register

endpackage

`default_nettype wire

// ==== src/lin_cfg_regs.sv ====
// per-channel gain and offset registers, write only, no readback
// address is {channel, select}; writes to a channel at or above NCH are dropped
// DWM and DWS must not exceed the 16-bit write data
`timescale 1ns/1ps
`default_nettype none

module lin_cfg_regs #(
  parameter  int unsigned NCH = lin_pkg::NCH,
  parameter  int unsigned DWM = lin_pkg::DWM,
  parameter  int unsigned DWS = lin_pkg::DWS,
  localparam int unsigned CHW = $clog2(NCH)
)(
  input  logic                          sti,
  input  logic                          rst_n,
  // write strobe, no handshake
  input  logic                          cfg_we,
  input  logic [CHW:0]                  cfg_addr,
  input  logic [lin_pkg::CFG_DW-1:0]    cfg_wdata,
  // per lane configuration
  output logic signed [DWM-1:0]         gain [NCH],
  output logic signed [DWS-1:0]         offs [NCH]
);

  //////////////////////////////////////////////////////////////////////
  // address decode
  //////////////////////////////////////////////////////////////////////

  // unity gain, DWM-2 fraction bits
  localparam logic signed [DWM-1:0] GAIN_ONE = DWM'(1) << (DWM-2);

  logic [CHW-1:0] wr_chan;  // target channel
  logic           wr_sel;   // gain or offset
  logic           wr_ok;    // strobe with channel in range

  assign wr_chan = cfg_addr[CHW:1];
  assign wr_sel  = cfg_addr[0];
  assign wr_ok   = cfg_we && (int'(wr_chan) < int'(NCH));

  //////////////////////////////////////////////////////////////////////
  // register array
  //////////////////////////////////////////////////////////////////////

  // reset gives identity transfer on every lane
  always_ff @(posedge sti) begin
    if (!rst_n) begin
      for (int k = 0; k < NCH; k++) begin
        gain[k] <= GAIN_ONE;
        offs[k] <= '0;
      end
    end else if (wr_ok) begin
      if (wr_sel == lin_pkg::CFG_SEL_GAIN) begin
        gain[wr_chan] <= signed'(cfg_wdata[DWM-1:0]);  // full word
      end else begin
        offs[wr_chan] <= signed'(cfg_wdata[DWS-1:0]);  // low bits only
      end
    end
  end

  // lanes see the new value one cycle after the strobe
  // no hazard protection against samples already in flight

endmodule

`default_nettype wire

// ==== src/lin_dispatch.sv ====
// one-entry input buffer that steers each sample to the lane named by its tag
// in_chan is assumed below NCH; full rate when the target lane keeps accepting
`timescale 1ns/1ps
`default_nettype none

module lin_dispatch #(
  parameter  int unsigned NCH = lin_pkg::NCH,
  parameter  int unsigned DWI = lin_pkg::DWI,
  localparam int unsigned CHW = $clog2(NCH)
)(
  input  logic                  sti,
  input  logic                  rst_n,
  // tagged input stream
  input  logic                  in_vld,
  output logic                  in_rdy,
  input  logic signed [DWI-1:0] in_dat,
  input  logic [CHW-1:0]        in_chan,
  input  logic                  in_lst,
  // lane side, shared data
  output logic [NCH-1:0]        ln_vld,
  input  logic [NCH-1:0]        ln_rdy,
  output logic signed [DWI-1:0] ln_dat,
  output logic                  ln_lst
);

  //////////////////////////////////////////////////////////////////////
  // buffer
  //////////////////////////////////////////////////////////////////////

  logic                  buf_vld;   // entry occupied
  logic signed [DWI-1:0] buf_dat;
  logic [CHW-1:0]        buf_chan;  // target lane
  logic                  buf_lst;

  logic                  buf_trn;   // entry taken by its lane
  logic                  in_trn;

  assign buf_trn = buf_vld & ln_rdy[buf_chan];
  assign in_rdy  = ~buf_vld | buf_trn;  // refill while draining
  assign in_trn  = in_vld & in_rdy;

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      buf_vld <= 1'b0;
    end else if (in_rdy) begin
      buf_vld <= in_vld;
    end
  end

  // payload, no reset
  always_ff @(posedge sti) begin
    if (in_trn) begin
      buf_dat  <= in_dat;
      buf_chan <= in_chan;
      buf_lst  <= in_lst;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // lane select
  //////////////////////////////////////////////////////////////////////

  // only the target lane sees valid
  always_comb begin
    for (int k = 0; k < NCH; k++) begin
      ln_vld[k] = buf_vld && (buf_chan == CHW'(k));
    end
  end

  assign ln_dat = buf_dat;  // same bus to every lane
  assign ln_lst = buf_lst;

endmodule

`default_nettype wire

// ==== src/lin_lane.sv ====
// one conditioning lane: sat(floor(x*gain / 2**(DWM-2)) + offs), result floored
// three register stages, 3 cycles without back-pressure, up to 3 samples held
// gain and offs are sampled live, so changes hit whatever is in flight
`timescale 1ns/1ps
`default_nettype none

module lin_lane #(
  parameter int unsigned DWI = lin_pkg::DWI,
  parameter int unsigned DWO = lin_pkg::DWO,
  parameter int unsigned DWM = lin_pkg::DWM
)(
  input  logic                  sti,
  input  logic                  rst_n,
  // input stream
  input  logic                  si_vld,
  output logic                  si_rdy,
  input  logic signed [DWI-1:0] si_dat,
  input  logic                  si_lst,
  // configuration
  input  logic signed [DWM-1:0] gain,
  input  logic signed [DWO-1:0] offs,
  // output stream
  output logic                  so_vld,
  input  logic                  so_rdy,
  output logic signed [DWO-1:0] so_dat,
  output logic                  so_lst
);

  localparam int unsigned PW = DWI + DWM;  // full product
  localparam int unsigned HW = DWI + 2;    // product after shift
  // sum must hold shifted product plus offset without wrap
  localparam int unsigned SW = ((HW > DWO) ? HW : DWO) + 1;

  //////////////////////////////////////////////////////////////////////
  // stage 1, multiply
  //////////////////////////////////////////////////////////////////////

  logic                 mul_vld;
  logic signed [PW-1:0] mul_dat;
  logic                 mul_lst;
  logic                 sum_in_rdy;  // stage 2 can take

  assign si_rdy = sum_in_rdy | ~mul_vld;

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      mul_vld <= 1'b0;
    end else if (si_rdy) begin
      mul_vld <= si_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (si_vld && si_rdy) begin
      mul_dat <= si_dat * gain;  // signed, full width
      mul_lst <= si_lst;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, shift and offset
  //////////////////////////////////////////////////////////////////////

  logic signed [PW-1:0] shf_dat;     // arithmetic shift = floor
  logic                 sum_vld;
  logic signed [SW-1:0] sum_dat;
  logic                 sum_lst;
  logic                 sat_in_rdy;  // stage 3 can take

  assign shf_dat    = mul_dat >>> (DWM-2);
  assign sum_in_rdy = sat_in_rdy | ~sum_vld;

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      sum_vld <= 1'b0;
    end else if (sum_in_rdy) begin
      sum_vld <= mul_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (mul_vld && sum_in_rdy) begin
      sum_dat <= SW'(shf_dat) + SW'(offs);  // both sign extended
      sum_lst <= mul_lst;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 3, saturate
  //////////////////////////////////////////////////////////////////////

  logic sum_ovf;  // upper bits not a pure sign extension

  assign sat_in_rdy = so_rdy | ~so_vld;
  assign sum_ovf    = (sum_dat[SW-1:DWO-1] != '0) && (sum_dat[SW-1:DWO-1] != '1);

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      so_vld <= 1'b0;
    end else if (sat_in_rdy) begin
      so_vld <= sum_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (sum_vld && sat_in_rdy) begin
      if (sum_ovf) begin
        // clip to the limit on the side of the sign
        so_dat <= {sum_dat[SW-1], {(DWO-1){~sum_dat[SW-1]}}};
      end else begin
        so_dat <= sum_dat[DWO-1:0];
      end
      so_lst <= sum_lst;
    end
  end

endmodule

`default_nettype wire

// ==== src/lin_collect.sv ====
// round-robin merge of the lane outputs into one registered tagged stream
// out_chan carries the index of the lane that produced the sample
// pointer moves past a lane only after it transfers, so no lane starves
`timescale 1ns/1ps
`default_nettype none

module lin_collect #(
  parameter  int unsigned NCH = lin_pkg::NCH,
  parameter  int unsigned DWO = lin_pkg::DWO,
  localparam int unsigned CHW = $clog2(NCH)
)(
  input  logic                  sti,
  input  logic                  rst_n,
  // lane outputs
  input  logic [NCH-1:0]        lo_vld,
  output logic [NCH-1:0]        lo_rdy,
  input  logic signed [DWO-1:0] lo_dat [NCH],
  input  logic [NCH-1:0]        lo_lst,
  // merged output stream
  output logic                  out_vld,
  input  logic                  out_rdy,
  output logic signed [DWO-1:0] out_dat,
  output logic [CHW-1:0]        out_chan,
  output logic                  out_lst
);

  //////////////////////////////////////////////////////////////////////
  // arbiter
  //////////////////////////////////////////////////////////////////////

  logic [CHW-1:0] rr_ptr;    // first lane to look at
  logic [CHW-1:0] gnt_idx;   // granted lane
  logic           gnt_vld;   // some lane is valid
  logic           out_free;  // output register empty or draining
  logic           lo_trn;    // granted lane transfers

  assign out_free = out_rdy | ~out_vld;
  assign lo_trn   = gnt_vld & out_free;

  // search from rr_ptr upward, wrapping at NCH
  always_comb begin
    int idx;
    gnt_vld = 1'b0;
    gnt_idx = rr_ptr;
    for (int i = 0; i < NCH; i++) begin
      idx = (int'(rr_ptr) + i) % int'(NCH);
      if (!gnt_vld && lo_vld[idx]) begin
        gnt_vld = 1'b1;
        gnt_idx = CHW'(idx);
      end
    end
  end

  always_comb begin
    for (int k = 0; k < NCH; k++) begin
      lo_rdy[k] = lo_trn && (gnt_idx == CHW'(k));  // one lane at a time
    end
  end

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      rr_ptr <= '0;
    end else if (lo_trn) begin
      rr_ptr <= (gnt_idx == CHW'(NCH-1)) ? '0 : gnt_idx + 1'b1;  // skip past winner
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (!rst_n) begin
      out_vld <= 1'b0;
    end else if (out_free) begin
      out_vld <= gnt_vld;
    end
  end

  // payload and tag, no reset
  always_ff @(posedge sti) begin
    if (lo_trn) begin
      out_dat  <= lo_dat[gnt_idx];
      out_lst  <= lo_lst[gnt_idx];
      out_chan <= gnt_idx;
    end
  end

endmodule

`default_nettype wire

// ==== src/lin_top.sv ====
// multi-channel linear conditioner, minimum latency 5 cycles input to out_vld
// order kept within a channel only; different channels may be reordered
// config writes during traffic take effect on whatever sample is in flight
`timescale 1ns/1ps
`default_nettype none

module lin_top #(
  parameter  int unsigned NCH = lin_pkg::NCH,
  parameter  int unsigned DWI = lin_pkg::DWI,
  parameter  int unsigned DWO = lin_pkg::DWO,
  parameter  int unsigned DWM = lin_pkg::DWM,
  localparam int unsigned CHW = $clog2(NCH)
)(
  input  logic                       sti,
  input  logic                       rst_n,
  // tagged input stream
  input  logic                       in_vld,
  output logic                       in_rdy,
  input  logic signed [DWI-1:0]      in_dat,
  input  logic [CHW-1:0]             in_chan,
  input  logic                       in_lst,
  // tagged output stream
  output logic                       out_vld,
  input  logic                       out_rdy,
  output logic signed [DWO-1:0]      out_dat,
  output logic [CHW-1:0]             out_chan,
  output logic                       out_lst,
  // configuration write port
  input  logic                       cfg_we,
  input  logic [CHW:0]               cfg_addr,
  input  logic [lin_pkg::CFG_DW-1:0] cfg_wdata
);

  //////////////////////////////////////////////////////////////////////
  // interconnect
  //////////////////////////////////////////////////////////////////////

  logic signed [DWM-1:0] gain [NCH];   // per lane gain
  logic signed [DWO-1:0] offs [NCH];   // per lane offset

  logic [NCH-1:0]        ln_vld;       // dispatcher to lanes
  logic [NCH-1:0]        ln_rdy;
  logic signed [DWI-1:0] ln_dat;
  logic                  ln_lst;

  logic [NCH-1:0]        lo_vld;       // lanes to collector
  logic [NCH-1:0]        lo_rdy;
  logic signed [DWO-1:0] lo_dat [NCH];
  logic [NCH-1:0]        lo_lst;

  //////////////////////////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////////////////////////

  lin_cfg_regs #(.NCH(NCH), .DWM(DWM), .DWS(DWO)) cfg_regs0 (
    .sti, .rst_n, .cfg_we, .cfg_addr, .cfg_wdata, .gain, .offs
  );

  lin_dispatch #(.NCH(NCH), .DWI(DWI)) dispatch0 (
    .sti, .rst_n, .in_vld, .in_rdy, .in_dat, .in_chan, .in_lst,
    .ln_vld, .ln_rdy, .ln_dat, .ln_lst
  );

  for (genvar k = 0; k < NCH; k++) begin : g_lane
    lin_lane #(.DWI(DWI), .DWO(DWO), .DWM(DWM)) lane0 (
      .sti, .rst_n,
      .si_vld (ln_vld[k]), .si_rdy (ln_rdy[k]), .si_dat (ln_dat), .si_lst (ln_lst),
      .gain   (gain[k]),   .offs   (offs[k]),
      .so_vld (lo_vld[k]), .so_rdy (lo_rdy[k]), .so_dat (lo_dat[k]), .so_lst (lo_lst[k])
    );
  end

  lin_collect #(.NCH(NCH), .DWO(DWO)) collect0 (
    .sti, .rst_n, .lo_vld, .lo_rdy, .lo_dat, .lo_lst,
    .out_vld, .out_rdy, .out_dat, .out_chan, .out_lst
  );

endmodule

`default_nettype wire

// ==== verif/lin_properties.sv ====
// output handshake and input ready checks, bound into lin_top
// only the top level ports are observed
`timescale 1ns/1ps
`default_nettype none

module lin_properties #(
  parameter  int unsigned NCH = lin_pkg::NCH,
  parameter  int unsigned DWO = lin_pkg::DWO,
  localparam int unsigned CHW = $clog2(NCH)
)(
  input logic                  sti,
  input logic                  rst_n,
  input logic                  in_rdy,
  input logic                  out_vld,
  input logic                  out_rdy,
  input logic signed [DWO-1:0] out_dat,
  input logic [CHW-1:0]        out_chan,
  input logic                  out_lst
);

  // output register empty right after a reset cycle
  a_reset_idle: assert property (@(posedge sti) !rst_n |=> !out_vld)
    else $error("out_vld high in the cycle after reset");

  // stalled output holds still until taken
  a_out_stable: assert property (@(posedge sti) disable iff (!rst_n)
    (out_vld && !out_rdy) |=>
      (out_vld && $stable(out_dat) && $stable(out_chan) && $stable(out_lst)))
    else $error("output changed or dropped while stalled");

  a_in_rdy_known: assert property (@(posedge sti) disable iff (!rst_n)
    !$isunknown(in_rdy))
    else $error("in_rdy unknown after reset");

  // tag register has no reset, so a valid output must carry a known tag
  a_chan_range: assert property (@(posedge sti) disable iff (!rst_n)
    out_vld |-> (!$isunknown(out_chan) && (int'(out_chan) < int'(NCH))))
    else $error("out_chan %0d not a known channel below the channel count", out_chan);

endmodule

bind lin_top lin_properties #(.NCH(NCH), .DWO(DWO)) props0 (
  .sti      (sti),
  .rst_n    (rst_n),
  .in_rdy   (in_rdy),
  .out_vld  (out_vld),
  .out_rdy  (out_rdy),
  .out_dat  (out_dat),
  .out_chan (out_chan),
  .out_lst  (out_lst)
);

`default_nettype wire

// ==== verif/lin_tb.sv ====
// directed testbench for lin_top, expected values from a floor and saturate model
// assumes NCH is a power of two, so every random tag names a real channel
// config is only rewritten on an empty pipeline
`timescale 1ns/1ps
`default_nettype none

module lin_tb;

  localparam int NCH = lin_pkg::NCH;
  localparam int CHW = lin_pkg::CHW;
  localparam int DWI = lin_pkg::DWI;
  localparam int DWO = lin_pkg::DWO;
  localparam int DWM = lin_pkg::DWM;

  // samples per test, also sizes the watchdog
  localparam int N_ID      = 32;
  localparam int N_GO      = 64;
  localparam int N_SAT     = 32;
  localparam int N_BP      = 200;
  localparam int N_FAIR    = 32;  // per channel
  localparam int N_TOTAL   = N_ID + N_GO + N_SAT + 6 + 1 + N_BP + N_FAIR * NCH;
  localparam int WD_CYCLES = N_TOTAL * 20 + 200;

  logic                  sti;
  logic                  rst_n;
  logic                  in_vld;
  logic                  in_rdy;
  logic signed [DWI-1:0] in_dat;
  logic [CHW-1:0]        in_chan;
  logic                  in_lst;
  logic                  out_vld;
  logic                  out_rdy = 1'b1;
  logic signed [DWO-1:0] out_dat;
  logic [CHW-1:0]        out_chan;
  logic                  out_lst;
  logic                  cfg_we;
  logic [CHW:0]          cfg_addr;
  logic [15:0]           cfg_wdata;

  lin_top #(.NCH(NCH), .DWI(DWI), .DWO(DWO), .DWM(DWM)) dut0 (
    .sti, .rst_n, .in_vld, .in_rdy, .in_dat, .in_chan, .in_lst,
    .out_vld, .out_rdy, .out_dat, .out_chan, .out_lst,
    .cfg_we, .cfg_addr, .cfg_wdata
  );

  //////////////////////////////////////////////////////////////////////
  // clock, cycle count, state
  //////////////////////////////////////////////////////////////////////

  initial sti = 1'b0;
  always #50 sti = ~sti;  // 100 ns period

  int cyc = 0;
  always @(posedge sti) cyc <= cyc + 1;

  logic [31:0]           rnd_state = 32'h16feef90;  // stimulus
  logic [31:0]           bp_state  = 32'h16feef90;  // out_rdy pattern
  logic                  bp_on     = 1'b0;
  logic                  fair_on   = 1'b0;
  string                 test_name = "reset";
  int                    n_chk_err = 0;
  int                    n_other_err = 0;
  int                    n_out = 0;
  int                    last_in_cyc = 0;
  int                    last_out_cyc = 0;

  logic signed [DWM-1:0] tb_gain [NCH];       // model copy of the registers
  logic signed [DWO-1:0] tb_offs [NCH];
  logic signed [DWO-1:0] exp_dat [NCH][$];    // expected, per channel in order
  logic                  exp_lst [NCH][$];
  logic [CHW-1:0]        exp_order [$];       // tags in input order, no stalls
  int                    out_cnt [NCH];
  int                    last_grant [NCH];
  logic                  seen [NCH];

  //////////////////////////////////////////////////////////////////////
  // lfsr and model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      rnd_state = lfsr_next(rnd_state);
      r = {r[30:0], rnd_state[0]};  // one step per bit
    end
    return r;
  endfunction

  // sat(floor(x*gain / 2**(DWM-2)) + offs)
  function automatic logic signed [DWO-1:0] model(int ch, logic signed [DWI-1:0] x);
    longint one;
    longint prod;
    longint q;
    longint hi;
    longint lo;
    one  = longint'(1) << (DWM-2);
    prod = longint'(x) * longint'(tb_gain[ch]);
    q    = prod / one;  // toward zero
    if (prod < 0 && q * one != prod) begin
      q = q - 1;        // make it floor
    end
    q  = q + longint'(tb_offs[ch]);
    hi = (longint'(1) << (DWO-1)) - 1;
    lo = -hi - 1;
    if (q > hi) begin
      q = hi;
    end else if (q < lo) begin
      q = lo;
    end
    return DWO'(q);
  endfunction

  function automatic int pending();
    int n;
    n = 0;
    for (int k = 0; k < NCH; k++) n += exp_dat[k].size();
    return n;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare tasks and output monitor
  //////////////////////////////////////////////////////////////////////

  task automatic check_dat(logic signed [DWO-1:0] exp, logic signed [DWO-1:0] act);
    if (act !== exp) begin
      n_chk_err++;
      $display("CHECK FAILED %s: out_dat expected %0d, actual %0d", test_name, exp, act);
    end
  endtask

  task automatic check_chan(logic [CHW-1:0] exp, logic [CHW-1:0] act);
    if (act !== exp) begin
      n_chk_err++;
      $display("CHECK FAILED %s: out_chan expected %0d, actual %0d", test_name, exp, act);
    end
  endtask

  task automatic check_lst(logic exp, logic act);
    if (act !== exp) begin
      n_chk_err++;
      $display("CHECK FAILED %s: out_lst expected %0b, actual %0b", test_name, exp, act);
    end
  endtask

  task automatic check_int(string what, int exp, int act);
    if (act != exp) begin
      n_chk_err++;
      $display("CHECK FAILED %s: %s expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic take_output();
    int ch;
    ch = int'(out_chan);
    n_out++;
    last_out_cyc = cyc;
    out_cnt[ch]++;
    if (exp_dat[ch].size() == 0) begin
      n_other_err++;
      $display("%s: output on channel %0d that was never sent", test_name, ch);
    end else begin
      check_dat(exp_dat[ch].pop_front(), out_dat);
      check_lst(exp_lst[ch].pop_front(), out_lst);
    end
    // fixed delay in every block without stalls, so tags leave in input order
    if (!bp_on && exp_order.size() != 0) begin
      check_chan(exp_order.pop_front(), out_chan);
    end
    // grants since this channel last came out
    if (fair_on && seen[ch] && (n_out - last_grant[ch] > NCH)) begin
      n_other_err++;
      $display("%s: channel %0d waited %0d grants between outputs", test_name, ch,
               n_out - last_grant[ch]);
    end
    seen[ch]       = 1'b1;
    last_grant[ch] = n_out;
  endtask

  always @(posedge sti) begin
    if (rst_n && out_vld && out_rdy) take_output();  // pre-edge values
  end

  // random stall only while bp_on
  always @(negedge sti) begin
    if (bp_on) begin
      bp_state = lfsr_next(bp_state);
      out_rdy  = bp_state[0];
    end else begin
      out_rdy = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // drive tasks, all start and end just after a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic write_cfg(int ch, logic sel, logic [15:0] data);
    cfg_we    = 1'b1;
    cfg_addr  = {CHW'(ch), sel};
    cfg_wdata = data;
    @(negedge sti);
    cfg_we = 1'b0;
    if (sel == lin_pkg::CFG_SEL_GAIN) begin
      tb_gain[ch] = data[DWM-1:0];  // whole word
    end else begin
      tb_offs[ch] = data[DWO-1:0];  // low bits
    end
  endtask

  task automatic send_sample(int ch, logic signed [DWI-1:0] x, logic lst);
    in_vld  = 1'b1;
    in_chan = CHW'(ch);
    in_dat  = x;
    in_lst  = lst;
    exp_dat[ch].push_back(model(ch, x));
    exp_lst[ch].push_back(lst);
    if (!bp_on) begin
      exp_order.push_back(CHW'(ch));
    end
    @(posedge sti);
    while (!in_rdy) @(posedge sti);
    last_in_cyc = cyc;
    @(negedge sti);  // valid stays up for a following sample
  endtask

  task automatic send_random();
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] l;
    c = rand_bits(CHW);
    d = rand_bits(DWI);
    l = rand_bits(1);
    send_sample(int'(c[CHW-1:0]), d[DWI-1:0], l[0]);
  endtask

  task automatic drain();
    in_vld = 1'b0;
    while (pending() != 0) @(negedge sti);
    repeat (2) @(negedge sti);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_identity();
    test_name = "identity";
    repeat (N_ID) send_random();
    drain();
  endtask

  task automatic test_gain_offset();
    logic [15:0] gains [4];
    logic [15:0] offsets [4];
    gains   = '{16'h2000, 16'hc000, 16'h6000, 16'he123};  // 0.5, -1.0, 1.5, about -0.48
    offsets = '{16'h0064, 16'hffce, 16'h0000, 16'h1f00};
    test_name = "gain_offset";
    for (int k = 0; k < NCH; k++) begin
      write_cfg(k, lin_pkg::CFG_SEL_GAIN, gains[k % 4]);
      write_cfg(k, lin_pkg::CFG_SEL_OFFS, offsets[k % 4]);
    end
    repeat (N_GO) send_random();
    drain();
  endtask

  task automatic test_saturation();
    logic [15:0] gains [4];
    logic [15:0] offsets [4];
    gains   = '{16'h7fff, 16'h7fff, 16'h8000, 16'h8000};  // near +2.0 and -2.0
    offsets = '{16'h1fff, 16'h2000, 16'h0000, 16'h1fff};
    test_name = "saturation";
    for (int k = 0; k < NCH; k++) begin
      write_cfg(k, lin_pkg::CFG_SEL_GAIN, gains[k % 4]);
      write_cfg(k, lin_pkg::CFG_SEL_OFFS, offsets[k % 4]);
    end
    send_sample(0, 14'sd8191, 1'b0);       // past the top
    send_sample(1 % NCH, -14'sd8192, 1'b1); // past the bottom
    send_sample(2 % NCH, -14'sd8192, 1'b0);
    send_sample(2 % NCH, 14'sd8191, 1'b0);
    send_sample(3 % NCH, 14'sd8191, 1'b1);
    send_sample(3 % NCH, -14'sd8192, 1'b0);
    repeat (N_SAT) send_random();
    drain();
  endtask

  task automatic test_latency();
    test_name = "latency";
    send_sample(0, 14'sd1234, 1'b1);
    drain();
    check_int("input to output cycles", 5, last_out_cyc - last_in_cyc);
  endtask

  task automatic test_backpressure();
    int n0;
    test_name = "backpressure";
    n0    = n_out;
    bp_on = 1'b1;
    repeat (N_BP) send_random();
    drain();
    bp_on = 1'b0;
    @(negedge sti);
    check_int("output count", N_BP, n_out - n0);  // no loss, no duplicate
  endtask

  task automatic test_fairness();
    test_name = "fairness";
    for (int k = 0; k < NCH; k++) begin
      out_cnt[k] = 0;
      seen[k]    = 1'b0;
    end
    fair_on = 1'b1;
    for (int i = 0; i < N_FAIR * NCH; i++) begin
      send_sample(i % NCH, DWI'(rand_bits(DWI)), (i % 8) == 7);
    end
    drain();
    fair_on = 1'b0;
    for (int k = 0; k < NCH; k++) check_int("outputs per channel", N_FAIR, out_cnt[k]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    in_vld    = 1'b0;
    in_dat    = '0;
    in_chan   = '0;
    in_lst    = 1'b0;
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    for (int k = 0; k < NCH; k++) begin
      tb_gain[k] = DWM'(1) << (DWM-2);  // 1.0 after reset
      tb_offs[k] = '0;
      out_cnt[k] = 0;
      seen[k]    = 1'b0;
    end
    repeat (2) @(negedge sti);
    rst_n = 1'b1;
    test_identity();
    test_gain_offset();
    test_saturation();
    test_latency();
    test_backpressure();
    test_fairness();
    $display("errors: %0d value, %0d other", n_chk_err, n_other_err);
    if (n_chk_err + n_other_err == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    repeat (WD_CYCLES) @(posedge sti);
    $display("timeout: run did not finish within %0d cycles in test %s", WD_CYCLES, test_name);
    $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/lin_pkg.sv
src/lin_cfg_regs.sv
src/lin_dispatch.sv
src/lin_lane.sv
src/lin_collect.sv
src/lin_top.sv
verif/lin_properties.sv
verif/lin_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run lin_tb with Verilator, result taken from sim.log
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module lin_tb -Mdir obj_dir -f files.f

status=0
./obj_dir/Vlin_tb 2>&1 | tee sim.log || status=$?

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  echo "RESULT: FAIL"
  exit 1
fi

echo "RESULT: PASS"
